//--- src/video_pkg.sv
package video_pkg;

  // one colour component per lane
  localparam int color_bits = 8;

  // one parallel TMDS symbol, sent lsb first by the serializer
  localparam int symbol_bits = 10;

  typedef logic [color_bits-1:0] color_t;
  typedef logic [symbol_bits-1:0] symbol_t;

  // DVI control symbols during blanking
  // index is {c1, c0}, on the blue lane {vsync, hsync}
  localparam symbol_t ctrl_sym_00 = 10'b1101010100;
  localparam symbol_t ctrl_sym_01 = 10'b0010101011;
  localparam symbol_t ctrl_sym_10 = 10'b0101010100;
  localparam symbol_t ctrl_sym_11 = 10'b1010101011;

  // clock lane, five ones then five zeros per pixel
  localparam symbol_t clock_lane_sym = 10'b1111100000;

endpackage

//--- src/video_timing.sv
`timescale 1ns/100ps

module video_timing #(
  parameter int h_active      = 1280,
  parameter int h_front_porch = 30,
  parameter int h_sync_pulse  = 64,
  parameter int h_back_porch  = 60,
  parameter int v_active      = 1024,
  parameter int v_front_porch = 3,
  parameter int v_sync_pulse  = 5,
  parameter int v_back_porch  = 10,
  parameter int x_bits        = 11,
  parameter int y_bits        = 11
) (
  input  logic              clk_pixel,
  input  logic              rst_n,
  output logic [x_bits-1:0] x,
  output logic [y_bits-1:0] y,
  output logic              hsync,
  output logic              vsync,
  output logic              blank
);

  localparam int h_total = h_active + h_front_porch + h_sync_pulse + h_back_porch;
  localparam int v_total = v_active + v_front_porch + v_sync_pulse + v_back_porch;

  // sync windows, counted from the start of the line or frame
  localparam int h_sync_start = h_active + h_front_porch;
  localparam int h_sync_end   = h_sync_start + h_sync_pulse;
  localparam int v_sync_start = v_active + v_front_porch;
  localparam int v_sync_end   = v_sync_start + v_sync_pulse;

  localparam logic [x_bits-1:0] x_last = x_bits'(h_total - 1);
  localparam logic [y_bits-1:0] y_last = y_bits'(v_total - 1);

  logic [x_bits-1:0] x_next;
  logic [y_bits-1:0] y_next;
  logic              hsync_next;
  logic              vsync_next;
  logic              blank_next;

  // next position, y steps when x wraps
  always_comb begin
    x_next = x + 1'b1;
    y_next = y;
    if (x == x_last) begin
      x_next = '0;
      if (y == y_last) begin
        y_next = '0;
      end else begin
        y_next = y + 1'b1;
      end
    end
  end

  // flags come from the next position so they line up with x and y
  always_comb begin
    blank_next = (x_next >= h_active) || (y_next >= v_active);
    hsync_next = (x_next >= h_sync_start) && (x_next < h_sync_end);
    vsync_next = (y_next >= v_sync_start) && (y_next < v_sync_end);
  end

  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      x     <= '0;
      y     <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      blank <= 1'b0;
    end else begin
      x     <= x_next;
      y     <= y_next;
      hsync <= hsync_next;
      vsync <= vsync_next;
      blank <= blank_next;
    end
  end

endmodule

//--- src/test_pattern.sv
`timescale 1ns/100ps

module test_pattern #(
  parameter int x_bits = 11,
  parameter int y_bits = 11
) (
  input  logic              clk_pixel,
  input  logic              rst_n,
  input  logic [x_bits-1:0] x,
  input  logic [y_bits-1:0] y,
  input  logic              hsync,
  input  logic              vsync,
  input  logic              blank,
  output video_pkg::color_t red,
  output video_pkg::color_t green,
  output video_pkg::color_t blue,
  output logic              hsync_out,
  output logic              vsync_out,
  output logic              blank_out
);

  video_pkg::color_t diagonal;

  // low bits of x + y, wraps every 256
  assign diagonal = video_pkg::color_t'(x) + video_pkg::color_t'(y);

  // gradients, no reset on the colour path
  always_ff @(posedge clk_pixel) begin
    red   <= video_pkg::color_t'(x);
    green <= video_pkg::color_t'(y);
    blue  <= diagonal;
  end

  // syncs ride along with the colour
  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
      blank_out <= 1'b1;
    end else begin
      hsync_out <= hsync;
      vsync_out <= vsync;
      blank_out <= blank;
    end
  end

endmodule

//--- src/tmds_encoder.sv
`timescale 1ns/100ps

module tmds_encoder (
  input  logic               clk_pixel,
  input  logic               rst_n,
  input  video_pkg::color_t  data,
  input  logic [1:0]         ctrl,
  input  logic               blank,
  output video_pkg::symbol_t symbol
);

  logic [3:0]                    data_ones;
  logic                          use_xnor;
  logic [video_pkg::color_bits:0] q_m;
  logic [3:0]                    q_ones;
  // ones minus zeros in q_m[7:0]
  logic signed [5:0]             balance;
  logic signed [5:0]             disparity;
  logic signed [5:0]             disparity_next;
  video_pkg::symbol_t            data_symbol;
  video_pkg::symbol_t            ctrl_symbol;

  always_comb begin
    data_ones = '0;
    for (int i = 0; i < video_pkg::color_bits; i++) begin
      data_ones = data_ones + 4'(data[i]);
    end
  end

  // xnor when the byte is heavy in ones, fewer transitions
  assign use_xnor = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data[0]);

  always_comb begin
    q_m[0] = data[0];
    for (int i = 1; i < video_pkg::color_bits; i++) begin
      if (use_xnor) begin
        q_m[i] = ~(q_m[i-1] ^ data[i]);
      end else begin
        q_m[i] = q_m[i-1] ^ data[i];
      end
    end
    q_m[video_pkg::color_bits] = ~use_xnor;
  end

  always_comb begin
    q_ones = '0;
    for (int i = 0; i < video_pkg::color_bits; i++) begin
      q_ones = q_ones + 4'(q_m[i]);
    end
  end

  assign balance = $signed({1'b0, q_ones, 1'b0}) - 6'sd8;

  // DC balancing against the running disparity
  always_comb begin
    if ((disparity == 6'sd0) || (q_ones == 4'd4)) begin
      data_symbol = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      if (q_m[8]) begin
        disparity_next = disparity + balance;
      end else begin
        disparity_next = disparity - balance;
      end
    end else if ((!disparity[5] && (q_ones > 4'd4)) ||
                 (disparity[5] && (q_ones < 4'd4))) begin
      // drifting the wrong way, invert the payload
      data_symbol    = {1'b1, q_m[8], ~q_m[7:0]};
      disparity_next = disparity - balance + $signed({4'b0, q_m[8], 1'b0});
    end else begin
      data_symbol    = {1'b0, q_m[8], q_m[7:0]};
      disparity_next = disparity + balance - $signed({4'b0, ~q_m[8], 1'b0});
    end
  end

  always_comb begin
    case (ctrl)
      2'b00:   ctrl_symbol = video_pkg::ctrl_sym_00;
      2'b01:   ctrl_symbol = video_pkg::ctrl_sym_01;
      2'b10:   ctrl_symbol = video_pkg::ctrl_sym_10;
      default: ctrl_symbol = video_pkg::ctrl_sym_11;
    endcase
  end

  // blanking restarts the balance from zero
  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      symbol    <= video_pkg::ctrl_sym_00;
      disparity <= '0;
    end else if (blank) begin
      symbol    <= ctrl_symbol;
      disparity <= '0;
    end else begin
      symbol    <= data_symbol;
      disparity <= disparity_next;
    end
  end

endmodule

//--- src/dvi_transmitter.sv
`timescale 1ns/100ps

module dvi_transmitter (
  input  logic               clk_pixel,
  input  logic               rst_n,
  input  video_pkg::color_t  red,
  input  video_pkg::color_t  green,
  input  video_pkg::color_t  blue,
  input  logic               hsync,
  input  logic               vsync,
  input  logic               blank,
  output video_pkg::symbol_t tmds_red,
  output video_pkg::symbol_t tmds_green,
  output video_pkg::symbol_t tmds_blue,
  output video_pkg::symbol_t tmds_clock
);

  video_pkg::color_t red_reg;
  video_pkg::color_t green_reg;
  video_pkg::color_t blue_reg;
  logic              hsync_reg;
  logic              vsync_reg;
  logic              blank_reg;

  // input stage keeps colour and sync aligned into the encoders
  always_ff @(posedge clk_pixel) begin
    red_reg   <= red;
    green_reg <= green;
    blue_reg  <= blue;
  end

  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      hsync_reg <= 1'b0;
      vsync_reg <= 1'b0;
      blank_reg <= 1'b1;
    end else begin
      hsync_reg <= hsync;
      vsync_reg <= vsync;
      blank_reg <= blank;
    end
  end

  // only blue carries the syncs
  tmds_encoder encode_red_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .data(red_reg),
    .ctrl(2'b00),
    .blank(blank_reg),
    .symbol(tmds_red)
  );

  tmds_encoder encode_green_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .data(green_reg),
    .ctrl(2'b00),
    .blank(blank_reg),
    .symbol(tmds_green)
  );

  tmds_encoder encode_blue_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .data(blue_reg),
    .ctrl({vsync_reg, hsync_reg}),
    .blank(blank_reg),
    .symbol(tmds_blue)
  );

  // clock lane leaves from a flop like the data lanes
  always_ff @(posedge clk_pixel) begin
    tmds_clock <= video_pkg::clock_lane_sym;
  end

endmodule

//--- src/led_blink.sv
`timescale 1ns/100ps

module led_blink #(
  parameter int counter_width = 28
) (
  input  logic       clk_pixel,
  input  logic       rst_n,
  output logic [7:0] led
);

  logic [counter_width-1:0] count;

  // free running, wraps silently
  always_ff @(posedge clk_pixel) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // slowest bits are the visible blink
  assign led = count[counter_width-1 -: 8];

endmodule

//--- src/video_test_top.sv
`timescale 1ns/100ps

module video_test_top #(
  parameter int h_active      = 1280,
  parameter int h_front_porch = 30,
  parameter int h_sync_pulse  = 64,
  parameter int h_back_porch  = 60,
  parameter int v_active      = 1024,
  parameter int v_front_porch = 3,
  parameter int v_sync_pulse  = 5,
  parameter int v_back_porch  = 10,
  parameter int x_bits        = 11,
  parameter int y_bits        = 11,
  parameter int counter_width = 28
) (
  input  logic               clk_pixel,
  input  logic               rst_n,
  output video_pkg::symbol_t tmds_red,
  output video_pkg::symbol_t tmds_green,
  output video_pkg::symbol_t tmds_blue,
  output video_pkg::symbol_t tmds_clock,
  output logic [7:0]         led
);

  logic [x_bits-1:0] x;
  logic [y_bits-1:0] y;
  logic              timing_hsync;
  logic              timing_vsync;
  logic              timing_blank;
  video_pkg::color_t pattern_red;
  video_pkg::color_t pattern_green;
  video_pkg::color_t pattern_blue;
  logic              pattern_hsync;
  logic              pattern_vsync;
  logic              pattern_blank;

  led_blink #(
    .counter_width(counter_width)
  ) blink_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .led(led)
  );

  // raster counters
  video_timing #(
    .h_active(h_active),
    .h_front_porch(h_front_porch),
    .h_sync_pulse(h_sync_pulse),
    .h_back_porch(h_back_porch),
    .v_active(v_active),
    .v_front_porch(v_front_porch),
    .v_sync_pulse(v_sync_pulse),
    .v_back_porch(v_back_porch),
    .x_bits(x_bits),
    .y_bits(y_bits)
  ) timing_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .x(x),
    .y(y),
    .hsync(timing_hsync),
    .vsync(timing_vsync),
    .blank(timing_blank)
  );

  test_pattern #(
    .x_bits(x_bits),
    .y_bits(y_bits)
  ) pattern_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .x(x),
    .y(y),
    .hsync(timing_hsync),
    .vsync(timing_vsync),
    .blank(timing_blank),
    .red(pattern_red),
    .green(pattern_green),
    .blue(pattern_blue),
    .hsync_out(pattern_hsync),
    .vsync_out(pattern_vsync),
    .blank_out(pattern_blank)
  );

  // parallel TMDS out, serializer lives outside this design
  dvi_transmitter dvi_instance (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .red(pattern_red),
    .green(pattern_green),
    .blue(pattern_blue),
    .hsync(pattern_hsync),
    .vsync(pattern_vsync),
    .blank(pattern_blank),
    .tmds_red(tmds_red),
    .tmds_green(tmds_green),
    .tmds_blue(tmds_blue),
    .tmds_clock(tmds_clock)
  );

endmodule

//--- dv/video_test_assertions.sv
`timescale 1ns/100ps

module video_test_assertions (
  input logic               clk_pixel,
  input logic               rst_n,
  input logic               hsync,
  input logic               vsync,
  input logic               blank,
  input logic               pattern_blank,
  input video_pkg::symbol_t tmds_blue,
  input logic signed [5:0]  red_disparity,
  input logic signed [5:0]  green_disparity,
  input logic signed [5:0]  blue_disparity
);

  logic blue_is_ctrl;

  assign blue_is_ctrl = (tmds_blue == video_pkg::ctrl_sym_00) ||
                        (tmds_blue == video_pkg::ctrl_sym_01) ||
                        (tmds_blue == video_pkg::ctrl_sym_10) ||
                        (tmds_blue == video_pkg::ctrl_sym_11);

  sync_inside_blank: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    (hsync || vsync) |-> blank)
    else $error("sync high outside the blanking interval");

  // pattern blank reaches the blue lane two edges later
  blue_ctrl_in_blank: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    pattern_blank |-> ##2 blue_is_ctrl)
    else $error("data symbol on the blue lane during blanking");

  red_disparity_range: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    (red_disparity >= -6'sd10) && (red_disparity <= 6'sd10))
    else $error("red encoder disparity out of range");

  green_disparity_range: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    (green_disparity >= -6'sd10) && (green_disparity <= 6'sd10))
    else $error("green encoder disparity out of range");

  blue_disparity_range: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    (blue_disparity >= -6'sd10) && (blue_disparity <= 6'sd10))
    else $error("blue encoder disparity out of range");

endmodule

bind video_test_top video_test_assertions assertions_instance (
  .clk_pixel(clk_pixel),
  .rst_n(rst_n),
  .hsync(timing_hsync),
  .vsync(timing_vsync),
  .blank(timing_blank),
  .pattern_blank(pattern_blank),
  .tmds_blue(tmds_blue),
  .red_disparity(dvi_instance.encode_red_instance.disparity),
  .green_disparity(dvi_instance.encode_green_instance.disparity),
  .blue_disparity(dvi_instance.encode_blue_instance.disparity)
);

//--- dv/video_test_tb.sv
`timescale 1ns/100ps

module video_test_tb;

  // small raster so that a few frames run quickly
  localparam int h_active      = 16;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse  = 3;
  localparam int h_back_porch  = 2;
  localparam int v_active      = 6;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse  = 2;
  localparam int v_back_porch  = 1;
  localparam int x_bits        = 5;
  localparam int y_bits        = 4;
  localparam int counter_width = 10;

  localparam int h_total      = h_active + h_front_porch + h_sync_pulse + h_back_porch;
  localparam int v_total      = v_active + v_front_porch + v_sync_pulse + v_back_porch;
  localparam int frame_cycles = h_total * v_total;
  localparam int reset_cycles = 4;
  localparam int pipe_delay   = 3;
  localparam int run_frames   = 3;
  localparam int cycle_limit  = 4 * frame_cycles + 64;

  logic               clk_pixel;
  logic               rst_n;
  video_pkg::symbol_t tmds_red;
  video_pkg::symbol_t tmds_green;
  video_pkg::symbol_t tmds_blue;
  video_pkg::symbol_t tmds_clock;
  logic [7:0]         led;

  int          cycle_count;
  int          model_x;
  int          model_y;
  // running ones minus zeros per lane, red green blue
  int          disparity [3];
  logic [31:0] seed;

  video_test_top #(
    .h_active(h_active),
    .h_front_porch(h_front_porch),
    .h_sync_pulse(h_sync_pulse),
    .h_back_porch(h_back_porch),
    .v_active(v_active),
    .v_front_porch(v_front_porch),
    .v_sync_pulse(v_sync_pulse),
    .v_back_porch(v_back_porch),
    .x_bits(x_bits),
    .y_bits(y_bits),
    .counter_width(counter_width)
  ) DUT (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .tmds_red(tmds_red),
    .tmds_green(tmds_green),
    .tmds_blue(tmds_blue),
    .tmds_clock(tmds_clock),
    .led(led)
  );

  always #10 clk_pixel = ~clk_pixel;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // undo the payload inversion, then the xor or xnor chain
  function automatic video_pkg::color_t decode_symbol(input video_pkg::symbol_t sym);
    video_pkg::color_t d;
    video_pkg::color_t q;
    d    = sym[9] ? ~sym[7:0] : sym[7:0];
    q[0] = d[0];
    for (int i = 1; i < video_pkg::color_bits; i++) begin
      q[i] = sym[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return q;
  endfunction

  function automatic int symbol_balance(input video_pkg::symbol_t sym);
    int ones;
    ones = 0;
    for (int i = 0; i < video_pkg::symbol_bits; i++) begin
      ones = ones + int'(sym[i]);
    end
    return 2 * ones - video_pkg::symbol_bits;
  endfunction

  function automatic video_pkg::symbol_t control_symbol(input logic c1, input logic c0);
    case ({c1, c0})
      2'b00:   return video_pkg::ctrl_sym_00;
      2'b01:   return video_pkg::ctrl_sym_01;
      2'b10:   return video_pkg::ctrl_sym_10;
      default: return video_pkg::ctrl_sym_11;
    endcase
  endfunction

  function automatic bit is_control_symbol(input video_pkg::symbol_t sym);
    return (sym == video_pkg::ctrl_sym_00) || (sym == video_pkg::ctrl_sym_01) ||
           (sym == video_pkg::ctrl_sym_10) || (sym == video_pkg::ctrl_sym_11);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_color(input string name, input video_pkg::color_t got,
                             input video_pkg::color_t expected);
    if (got !== expected) begin
      abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  task automatic check_symbol(input string name, input video_pkg::symbol_t got,
                              input video_pkg::symbol_t expected);
    if (got !== expected) begin
      abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] got,
                           input logic [7:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
    end
  endtask

  // one lane, either a decoded pixel or a control symbol
  task automatic check_lane(input string name, input video_pkg::symbol_t sym, input int lane,
                            input bit active, input video_pkg::color_t expected,
                            input video_pkg::symbol_t expected_ctrl);
    if (active) begin
      if (is_control_symbol(sym)) begin
        abort_run($sformatf("control symbol on %s during active video", name));
      end
      check_color(name, decode_symbol(sym), expected);
      disparity[lane] = disparity[lane] + symbol_balance(sym);
      if ((disparity[lane] > 10) || (disparity[lane] < -10)) begin
        abort_run($sformatf("running disparity on %s drifted to %0d", name, disparity[lane]));
      end
    end else begin
      check_symbol(name, sym, expected_ctrl);
      disparity[lane] = 0;
    end
  endtask

  task automatic check_sample(input int k);
    bit hs;
    bit vs;
    bit active;
    check_symbol("tmds_clock", tmds_clock, video_pkg::clock_lane_sym);
    check_led("led", led, 8'(k >> (counter_width - 8)));
    if (k < pipe_delay) begin
      check_symbol("tmds_red", tmds_red, video_pkg::ctrl_sym_00);
      check_symbol("tmds_green", tmds_green, video_pkg::ctrl_sym_00);
      check_symbol("tmds_blue", tmds_blue, video_pkg::ctrl_sym_00);
    end else begin
      active = (model_x < h_active) && (model_y < v_active);
      hs = (model_x >= h_active + h_front_porch) &&
           (model_x < h_active + h_front_porch + h_sync_pulse);
      vs = (model_y >= v_active + v_front_porch) &&
           (model_y < v_active + v_front_porch + v_sync_pulse);
      check_lane("tmds_red", tmds_red, 0, active, video_pkg::color_t'(model_x),
                 video_pkg::ctrl_sym_00);
      check_lane("tmds_green", tmds_green, 1, active, video_pkg::color_t'(model_y),
                 video_pkg::ctrl_sym_00);
      check_lane("tmds_blue", tmds_blue, 2, active, video_pkg::color_t'(model_x + model_y),
                 control_symbol(vs, hs));
      model_x = model_x + 1;
      if (model_x == h_total) begin
        model_x = 0;
        model_y = (model_y == v_total - 1) ? 0 : model_y + 1;
      end
    end
  endtask

  always @(posedge clk_pixel) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      abort_run("timeout: frames not completed");
    end
  end

  initial begin
    int extra_cycles;
    clk_pixel   = 1'b0;
    rst_n       = 1'b0;
    cycle_count = 0;
    model_x     = 0;
    model_y     = 0;
    foreach (disparity[i]) begin
      disparity[i] = 0;
    end
    seed         = xorshift32(32'hf3ba_187b);
    extra_cycles = int'(seed[3:0]);
    repeat (reset_cycles + extra_cycles) @(posedge clk_pixel);
    #1 rst_n = 1'b1;
    // sample k sees the outputs of the k-th edge after release
    for (int k = 0; k < pipe_delay + run_frames * frame_cycles; k++) begin
      @(negedge clk_pixel);
      check_sample(k);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- sim.f
src/video_pkg.sv
src/video_timing.sv
src/test_pattern.sv
src/tmds_encoder.sv
src/dvi_transmitter.sv
src/led_blink.sv
src/video_test_top.sv
dv/video_test_assertions.sv
dv/video_test_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = video_test_tb
FILE_LIST = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
